// ==== build.f ====
hw/boardPkg.sv
hw/busBridge.sv
hw/dataMemory.sv
hw/intervalTimer.sv
hw/inputPanel.sv
hw/indicatorPanel.sv
hw/boardTop.sv
testbench/boardTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the board testbench with Verilator, runs it and judges the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module boardTb -Mdir obj_dir -o boardSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/boardSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
fi

if grep -q "Simulation completed successfully" sim.log; then
    echo "RESULT: PASS"
    exit 0
fi
echo "RESULT: FAIL"
exit 1

// ==== testbench/boardTb.sv ====
// Testbench for boardTop; acts as the processor on the bus and checks every device against a model
`timescale 1ns/1ps

module boardTb import boardPkg::*; ();

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 16;
    localparam int memWords     = 1024;
    localparam int memOps       = 200;
    localparam int scanLen      = 4 * (2 ** 4) + 8;
    localparam int inputRounds  = 8;
    localparam int maxPreset    = 30;
    localparam int marginCycles = 200;
    // Sum of the per-test cycle counts
    localparam int budgetCycles = resetCycles + memWords + 2 * memOps + 8 + scanLen + 8
                                + inputRounds * 5 + 8 * (maxPreset + 1) + 40 + marginCycles;

    // Hex digit shapes with bit 0 as segment a
    localparam logic [6:0] segCode [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic                 clk;
    logic                 arstN;
    busReq                req;
    logic [wordWidth-1:0] rdata;
    logic [1:0]           irq;
    logic [7:0][7:0]      dipSwitch;
    logic [7:0]           userKey;
    logic [wordWidth-1:0] led;
    logic [7:0]           segment;
    logic [3:0]           digitSel;

    logic [15:0]          lfsr = 16'd13;
    logic [wordWidth-1:0] memModel [memWords];
    string                testName;

    boardTop dut0 (
        .clk(clk), .arstN(arstN), .req(req), .rdata(rdata), .irq(irq),
        .dipSwitch(dipSwitch), .userKey(userKey), .led(led),
        .segment(segment), .digitSel(digitSel)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    initial begin
        #(budgetCycles * clkPeriod);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $fatal(1);
    end

    // Galois LFSR with taps 16 14 13 11
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsr[0];
        lfsr = lfsr >> 1;
        if (outBit) lfsr = lfsr ^ 16'hB400;
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) v = {v[30:0], nextBit()};
        return v;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else
            abortRun($sformatf("MISMATCH %s %s expected %h actual %h",
                               testName, label, expected, actual));
    endtask

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic busWrite(input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] be);
        req.addr  = addr;
        req.wdata = data;
        req.be    = be;
        req.we    = 1'b1;
        tick();
        req.we = 1'b0;
    endtask

    // Read data is combinational and sampled 1 ns after the address
    task automatic expectRead(input logic [15:0] addr, input logic [31:0] expected,
                              input string label);
        req.addr = addr;
        req.we   = 1'b0;
        #1;
        checkValue(label, expected, rdata);
    endtask

    initial begin
        logic [31:0] data;
        logic [3:0]  be;
        logic [63:0] dip;
        logic [7:0]  pressed;
        logic [3:0]  seen;
        int          idx;
        int          preset;
        int          lowCount;
        int          k;

        req       = '0;
        dipSwitch = '1;
        userKey   = 8'hFF;
        arstN     = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #2;
        testName = "reset";
        checkValue("irq", 32'h0, 32'(irq));
        checkValue("led", 32'h0, led);
        checkValue("digitSel", 32'hF, 32'(digitSel));
        arstN = 1'b1;
        expectRead(displayAddr, 32'h0, "display");
        expectRead(timerCtrlAddr, 32'h0, "timer control");
        tick();

        testName = "memory";
        // Fill pattern carries the whole byte address
        for (int i = 0; i < memWords; i++) begin
            data = {16'(i * 4) ^ 16'h5A3C, ~16'(i * 4)};
            busWrite(16'(i * 4), data, 4'hF);
            memModel[i] = data;
        end
        for (int n = 0; n < memOps; n++) begin
            idx  = int'(randBits(10));
            be   = 4'(randBits(4));
            data = randBits(32);
            busWrite(16'(idx * 4), data, be);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) memModel[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
        for (int n = 0; n < memOps; n++) begin
            idx = int'(randBits(10));
            expectRead(16'(idx * 4), memModel[idx], $sformatf("word %0d", idx));
            tick();
        end
        expectRead(16'h1000, 32'h0, "unmapped 1000");
        expectRead(16'h7F30, 32'h0, "unmapped 7F30");
        expectRead(16'hFFFC, 32'h0, "unmapped FFFC");
        tick();

        testName = "indicator";
        data = randBits(32);
        busWrite(ledAddr, data, 4'hF);
        checkValue("led pins", data, led);
        expectRead(ledAddr, data, "led readback");
        tick();
        data = randBits(32);
        busWrite(displayAddr, data, 4'hF);
        expectRead(displayAddr, data, "display readback");
        tick();
        seen = '0;
        for (int n = 0; n < scanLen; n++) begin
            tick();
            lowCount = 0;
            k = 0;
            for (int d = 0; d < 4; d++) begin
                if (!digitSel[d]) begin
                    lowCount++;
                    k = d;
                end
            end
            checkValue("digits active", 32'd1, 32'(lowCount));
            seen[k] = 1'b1;
            checkValue($sformatf("segment digit %0d", k), {25'h0, segCode[data[k*4 +: 4]]},
                       32'(segment));
        end
        checkValue("digits scanned", 32'hF, 32'(seen));

        testName = "inputs";
        for (int n = 0; n < inputRounds; n++) begin
            dip       = {randBits(32), randBits(32)};
            dipSwitch = dip;
            userKey   = 8'(randBits(8));
            repeat (4) tick();
            expectRead(dipLowAddr, ~dip[31:0], "banks 0-3");
            expectRead(dipHighAddr, ~dip[63:32], "banks 4-7");
            expectRead(keyAddr, {24'h0, ~userKey}, "keys");
            tick();
        end

        testName = "timerOneShot";
        preset = int'(randBits(5) % 30) + 1;
        busWrite(timerPresetAddr, 32'(preset), 4'hF);
        busWrite(timerCtrlAddr, 32'h9, 4'hF);
        for (int n = 1; n <= preset + 2; n++) begin
            tick();
            checkValue($sformatf("irq0 cycle %0d", n), 32'(n == preset + 2), 32'(irq[0]));
        end
        repeat (5) tick();
        checkValue("irq0 held", 32'h1, 32'(irq[0]));
        expectRead(timerCountAddr, 32'h0, "count");
        expectRead(timerCtrlAddr, 32'h8, "control");
        tick();

        testName = "timerReload";
        preset = int'(randBits(5) % 30) + 1;
        busWrite(timerPresetAddr, 32'(preset), 4'hF);
        busWrite(timerCtrlAddr, 32'hB, 4'hF);
        // Pulses every preset + 1 cycles after the first
        for (int n = 1; n <= 3 * preset + 5; n++) begin
            tick();
            checkValue($sformatf("irq0 cycle %0d", n),
                       32'(n >= preset + 2 && (n - preset - 2) % (preset + 1) == 0),
                       32'(irq[0]));
        end
        busWrite(timerCtrlAddr, 32'h3, 4'hF);
        for (int n = 1; n <= 3 * (preset + 1) + 4; n++) begin
            tick();
            checkValue($sformatf("masked irq0 cycle %0d", n), 32'h0, 32'(irq[0]));
        end
        busWrite(timerCtrlAddr, 32'h0, 4'hF);

        testName = "keyIrq";
        userKey = 8'hFF;
        repeat (4) tick();
        busWrite(keyAddr, 32'h0, 4'hF);
        checkValue("irq1 idle", 32'h0, 32'(irq[1]));
        pressed = 8'(randBits(8));
        if (pressed == 8'h0) pressed = 8'h01;
        userKey = ~pressed;
        for (int n = 1; n <= 3; n++) begin
            tick();
            checkValue($sformatf("irq1 cycle %0d", n), 32'(n == 3), 32'(irq[1]));
        end
        repeat (2) tick();
        checkValue("irq1 held", 32'h1, 32'(irq[1]));
        busWrite(keyAddr, 32'h0, 4'hF);
        for (int n = 0; n < 6; n++) begin
            checkValue($sformatf("irq1 cleared %0d", n), 32'h0, 32'(irq[1]));
            tick();
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== hw/boardTop.sv ====
// Board peripheral top level; connects the bus bridge to memory, timer and both panels
`timescale 1ns/1ps

module boardTop import boardPkg::*; #(
    parameter int memWords    = 1024,
    parameter int scanDivBits = 4
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  busReq                req,
    output logic [wordWidth-1:0] rdata,
    output logic [1:0]           irq,
    input  logic [7:0][7:0]      dipSwitch,
    input  logic [7:0]           userKey,
    output logic [wordWidth-1:0] led,
    output logic [7:0]           segment,
    output logic [3:0]           digitSel
);

    logic                 memWe;
    logic                 timerWe;
    logic                 inputWe;
    logic                 indicatorWe;
    logic [wordWidth-1:0] memRd;
    logic [wordWidth-1:0] timerRd;
    logic [wordWidth-1:0] inputRd;
    logic [wordWidth-1:0] indicatorRd;
    logic                 timerIrq;
    logic                 keyIrq;

    busBridge #(.memWords(memWords)) bridge0 (
        .req(req),
        .memWe(memWe),
        .timerWe(timerWe),
        .inputWe(inputWe),
        .indicatorWe(indicatorWe),
        .memRd(memRd),
        .timerRd(timerRd),
        .inputRd(inputRd),
        .indicatorRd(indicatorRd),
        .timerIrq(timerIrq),
        .keyIrq(keyIrq),
        .rdata(rdata),
        .irq(irq)
    );

    dataMemory #(.memWords(memWords)) mem0 (
        .clk(clk), .memWe(memWe), .addr(req.addr),
        .wdata(req.wdata), .be(req.be), .rdata(memRd)
    );

    // Device 0, interval timer
    intervalTimer timer0 (
        .clk(clk), .arstN(arstN), .we(timerWe), .addr(req.addr),
        .wdata(req.wdata), .rdata(timerRd), .timerIrq(timerIrq)
    );

    // Device 1, switches and keys
    inputPanel input0 (
        .clk(clk), .arstN(arstN), .we(inputWe), .addr(req.addr),
        .dipSwitch(dipSwitch), .userKey(userKey), .rdata(inputRd), .keyIrq(keyIrq)
    );

    // Device 2, LEDs and display
    indicatorPanel #(.scanDivBits(scanDivBits)) indicator0 (
        .clk(clk), .arstN(arstN), .we(indicatorWe), .addr(req.addr),
        .wdata(req.wdata), .rdata(indicatorRd), .led(led),
        .segment(segment), .digitSel(digitSel)
    );

endmodule

// ==== hw/indicatorPanel.sv ====
// LED and four-digit seven-segment display device with a free-running digit scan
`timescale 1ns/1ps

module indicatorPanel import boardPkg::*; #(
    parameter int scanDivBits = 4
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 we,
    input  logic [addrWidth-1:0] addr,
    input  logic [wordWidth-1:0] wdata,
    output logic [wordWidth-1:0] rdata,
    output logic [wordWidth-1:0] led,
    output logic [7:0]           segment,
    output logic [3:0]           digitSel
);

    logic [wordWidth-1:0]   display;
    logic [scanDivBits+1:0] scanCount;
    logic [1:0]             digit;
    logic [3:0]             nibble;

    // Segments active high, bit 0 is a through bit 6 is g
    function automatic logic [6:0] hexToSeg(input logic [3:0] nib);
        case (nib)
            4'h0:    return 7'h3F;
            4'h1:    return 7'h06;
            4'h2:    return 7'h5B;
            4'h3:    return 7'h4F;
            4'h4:    return 7'h66;
            4'h5:    return 7'h6D;
            4'h6:    return 7'h7D;
            4'h7:    return 7'h07;
            4'h8:    return 7'h7F;
            4'h9:    return 7'h6F;
            4'hA:    return 7'h77;
            4'hB:    return 7'h7C;
            4'hC:    return 7'h39;
            4'hD:    return 7'h5E;
            4'hE:    return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            led     <= '0;
            display <= '0;
        end else if (we) begin
            if (addr == ledAddr) begin
                led <= wdata;
            end
            if (addr == displayAddr) begin
                display <= wdata;
            end
        end
    end

    // Top two counter bits pick the digit
    assign digit  = scanCount[scanDivBits+1 -: 2];
    assign nibble = display[digit*4 +: 4];

    // Select and segments registered together so they stay aligned
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            scanCount <= '0;
            digitSel  <= 4'hF;
            segment   <= '0;
        end else begin
            scanCount <= scanCount + 1'b1;
            digitSel  <= ~(4'b0001 << digit);
            segment   <= {1'b0, hexToSeg(nibble)};
        end
    end

    always_comb begin
        case (addr)
            ledAddr:     rdata = led;
            displayAddr: rdata = display;
            default:     rdata = '0;
        endcase
    end

endmodule

// ==== hw/inputPanel.sv ====
// Switch and key input device; synchronizes active-low pins and flags key presses
`timescale 1ns/1ps

module inputPanel import boardPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 we,
    input  logic [addrWidth-1:0] addr,
    input  logic [7:0][7:0]      dipSwitch,
    input  logic [7:0]           userKey,
    output logic [wordWidth-1:0] rdata,
    output logic                 keyIrq
);

    logic [7:0][7:0] dipMeta;
    logic [7:0][7:0] dipSync;
    logic [7:0]      keyMeta;
    logic [7:0]      keySync;
    logic [7:0]      keyPrev;
    logic            keyRise;

    // Pins are active low, store them inverted
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dipMeta <= '0;
            dipSync <= '0;
            keyMeta <= '0;
            keySync <= '0;
            keyPrev <= '0;
        end else begin
            dipMeta <= ~dipSwitch;
            dipSync <= dipMeta;
            keyMeta <= ~userKey;
            keySync <= keyMeta;
            keyPrev <= keySync;
        end
    end

    assign keyRise = |(keySync & ~keyPrev);

    // Clear wins over a new press in the same cycle
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            keyIrq <= 1'b0;
        end else if (we && (addr == keyAddr)) begin
            keyIrq <= 1'b0;
        end else if (keyRise) begin
            keyIrq <= 1'b1;
        end
    end

    always_comb begin
        case (addr)
            dipLowAddr:  rdata = dipSync[3:0];
            dipHighAddr: rdata = dipSync[7:4];
            keyAddr:     rdata = {{(wordWidth-8){1'b0}}, keySync};
            default:     rdata = '0;
        endcase
    end

endmodule

// ==== hw/intervalTimer.sv ====
// Interval timer device with control, preset and count registers and a maskable interrupt
`timescale 1ns/1ps

module intervalTimer import boardPkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 we,
    input  logic [addrWidth-1:0] addr,
    input  logic [wordWidth-1:0] wdata,
    output logic [wordWidth-1:0] rdata,
    output logic                 timerIrq
);

    // Control register layout, bit 2 is spare but kept for readback
    typedef struct packed {
        logic     irqMask;
        logic     spare;
        timerMode mode;
        logic     enable;
    } timerCtrl;

    timerCtrl             ctrl;
    logic [wordWidth-1:0] preset;
    logic [wordWidth-1:0] count;
    timerState            state;
    logic                 ctrlWrite;
    logic                 presetWrite;

    assign ctrlWrite   = we && (addr == timerCtrlAddr);
    assign presetWrite = we && (addr == timerPresetAddr);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            preset <= '0;
        end else if (presetWrite) begin
            preset <= wdata;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ctrl     <= '0;
            count    <= '0;
            state    <= stIdle;
            timerIrq <= 1'b0;
        end else if (ctrlWrite) begin
            // Any control write restarts or stops and drops the irq
            ctrl     <= timerCtrl'(wdata[3:0]);
            timerIrq <= 1'b0;
            state    <= wdata[0] ? stLoad : stIdle;
        end else begin
            case (state)
                stLoad: begin
                    count <= preset;
                    state <= stCount;
                end
                stCount: begin
                    if (count == '0) begin
                        timerIrq <= ctrl.irqMask;
                        if (ctrl.mode == modeReload) begin
                            count <= preset;
                        end else begin
                            ctrl.enable <= 1'b0;
                            state       <= stHold;
                        end
                    end else begin
                        count    <= count - 1'b1;
                        timerIrq <= 1'b0;
                    end
                end
                // Idle waits for enable, hold keeps the irq level
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (addr)
            timerCtrlAddr:   rdata = {{(wordWidth-4){1'b0}}, ctrl};
            timerPresetAddr: rdata = preset;
            timerCountAddr:  rdata = count;
            default:         rdata = '0;
        endcase
    end

endmodule

// ==== hw/dataMemory.sv ====
// Word-addressed data RAM with byte enables; written at the clock edge, read combinationally
`timescale 1ns/1ps

module dataMemory import boardPkg::*; #(
    parameter int memWords = 1024
) (
    input  logic                   clk,
    input  logic                   memWe,
    input  logic [addrWidth-1:0]   addr,
    input  logic [wordWidth-1:0]   wdata,
    input  logic [wordWidth/8-1:0] be,
    output logic [wordWidth-1:0]   rdata
);

    localparam int idxBits = $clog2(memWords);

    logic [wordWidth-1:0] mem [memWords];
    logic [idxBits-1:0]   wordIdx;

    // Byte address to word index
    assign wordIdx = addr[idxBits+1:2];

    always_ff @(posedge clk) begin
        if (memWe) begin
            for (int b = 0; b < wordWidth / 8; b++) begin
                // Untouched bytes keep their old value
                if (be[b]) begin
                    mem[wordIdx][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end
        end
    end

    assign rdata = mem[wordIdx];

endmodule

// ==== hw/busBridge.sv ====
// Address decoder between processor bus and devices; steers writes, muxes reads, packs irqs
`timescale 1ns/1ps

module busBridge import boardPkg::*; #(
    parameter int memWords = 1024
) (
    input  busReq                 req,
    output logic                  memWe,
    output logic                  timerWe,
    output logic                  inputWe,
    output logic                  indicatorWe,
    input  logic [wordWidth-1:0]  memRd,
    input  logic [wordWidth-1:0]  timerRd,
    input  logic [wordWidth-1:0]  inputRd,
    input  logic [wordWidth-1:0]  indicatorRd,
    input  logic                  timerIrq,
    input  logic                  keyIrq,
    output logic [wordWidth-1:0]  rdata,
    output logic [1:0]            irq
);

    deviceSel             target;
    logic [addrWidth-1:0] memOffset;
    logic                 memHit;

    // Memory covers memWords words from memBase
    assign memOffset = req.addr - memBase;
    assign memHit    = 32'(memOffset) < 32'(memWords) * 32'd4;

    // Device windows match on the upper 12 address bits
    always_comb begin
        if (memHit) begin
            target = selMem;
        end else if (req.addr[addrWidth-1:4] == timerCtrlAddr[addrWidth-1:4]) begin
            target = selTimer;
        end else if (req.addr[addrWidth-1:4] == dipLowAddr[addrWidth-1:4]) begin
            target = selInput;
        end else if (req.addr[addrWidth-1:4] == ledAddr[addrWidth-1:4]) begin
            target = selIndicator;
        end else begin
            target = selNone;
        end
    end

    // Only the selected device sees the strobe
    assign memWe       = req.we && (target == selMem);
    assign timerWe     = req.we && (target == selTimer);
    assign inputWe     = req.we && (target == selInput);
    assign indicatorWe = req.we && (target == selIndicator);

    always_comb begin
        case (target)
            selMem:       rdata = memRd;
            selTimer:     rdata = timerRd;
            selInput:     rdata = inputRd;
            selIndicator: rdata = indicatorRd;
            default:      rdata = '0;
        endcase
    end

    // Bit 0 timer, bit 1 keys
    assign irq = {keyIrq, timerIrq};

endmodule

// ==== hw/boardPkg.sv ====
// Shared bus types, address map and widths; imported by every board module
package boardPkg;

    // Bus widths
    localparam int wordWidth = 32;
    localparam int addrWidth = 16;

    // One processor bus request, no handshake
    typedef struct packed {
        logic [addrWidth-1:0]   addr;
        logic [wordWidth-1:0]   wdata;
        logic                   we;
        logic [wordWidth/8-1:0] be;
    } busReq;

    // Bus target after address decode
    typedef enum logic [2:0] {
        selMem,
        selTimer,
        selInput,
        selIndicator,
        selNone
    } deviceSel;

    // Memory window starts here, size comes from memWords
    localparam logic [addrWidth-1:0] memBase = 16'h0000;

    // Timer registers
    localparam logic [addrWidth-1:0] timerCtrlAddr   = 16'h7F00;
    localparam logic [addrWidth-1:0] timerPresetAddr = 16'h7F04;
    localparam logic [addrWidth-1:0] timerCountAddr  = 16'h7F08;

    // Switch banks 0-3 and 4-7, then the user keys
    localparam logic [addrWidth-1:0] dipLowAddr  = 16'h7F10;
    localparam logic [addrWidth-1:0] dipHighAddr = 16'h7F14;
    localparam logic [addrWidth-1:0] keyAddr     = 16'h7F18;

    // LED word and display word
    localparam logic [addrWidth-1:0] ledAddr     = 16'h7F20;
    localparam logic [addrWidth-1:0] displayAddr = 16'h7F24;

    // Timer control mode field
    typedef enum logic [0:0] {
        modeOneShot = 1'b0,
        modeReload  = 1'b1
    } timerMode;

    // Timer FSM
    typedef enum logic [1:0] {
        stIdle,
        stLoad,
        stCount,
        stHold
    } timerState;

endpackage
